// File: hdl/ping_rx_pkg.sv
// Shared types and constants of the ping receive checker
// Byte stream is one byte per beat, so no keep mask exists
// Expected checksums in the echo template are fixed at zero
package ping_rx_pkg;

	localparam int HEADER_BYTES = 40; // Leading bytes checked against the template
	localparam int ID_HI_INDEX  = 40;
	localparam int ID_LO_INDEX  = 41; // Frame needs 42 bytes to carry a full id
	localparam int INDEX_W      = 8;  // Byte position saturates at 255

	// ICMP type byte of the expected echo
	typedef enum logic [7:0] {
		ECHO_REPLY   = 8'h00,
		ECHO_REQUEST = 8'h08
	} echo_type_e;

	typedef enum logic [1:0] {
		STATUS_OK       = 2'd0,
		STATUS_MISMATCH = 2'd1,
		STATUS_SHORT    = 2'd2
	} result_status_e;

	// Static while frames flow
	typedef struct packed {
		logic [47:0] mac_dst;
		logic [47:0] mac_src;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] frame_id;
		logic [15:0] log_id;
		echo_type_e  echo_type;
	} ping_config_t;

	typedef struct packed {
		logic [7:0]         data;
		logic               last;
		logic [INDEX_W-1:0] index; // Position within the frame
	} rx_beat_t;

	typedef struct packed {
		logic [15:0]    ping_id;
		result_status_e status;
	} ping_result_t;

endpackage

// File: hdl/rx_byte_indexer.sv
// Receive stream cannot stall, every valid beat is taken
// A gap in s_valid restarts the byte count of the frame
`timescale 1ns/1ps

module rx_byte_indexer import ping_rx_pkg::*; (
	input  logic       clk_rx,
	input  logic       rst_rx,
	input  logic [7:0] s_data,
	input  logic       s_last,
	input  logic       s_valid,
	output rx_beat_t   beat,
	output logic       beat_valid
);

	logic [INDEX_W-1:0] pos; // Position of the next incoming byte

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			pos        <= '0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= s_valid;
			if (!s_valid || s_last)
				pos <= '0; // Next byte starts a new frame
			else if (pos != '1)
				pos <= pos + 1'b1; // Hold at 255 on long frames
		end
	end

	// Indexed beat, qualified by beat_valid
	always_ff @(posedge clk_rx) begin
		beat.data  <= s_data;
		beat.last  <= s_last;
		beat.index <= pos;
	end

endmodule

// File: hdl/echo_header_matcher.sv
// Checks header bytes 0 to 39 against the echo template built from cfg
// cfg must not change while a frame is in flight
// Bytes at index 40 and above are ignored here
`timescale 1ns/1ps

module echo_header_matcher import ping_rx_pkg::*; (
	input  logic         clk_rx,
	input  logic         rst_rx,
	input  ping_config_t cfg,
	input  rx_beat_t     beat,
	input  logic         beat_valid,
	output logic         match_done,
	output logic         header_ok
);

	logic [0:HEADER_BYTES-1][7:0] tmpl; // Entry 0 is the first byte on the wire
	logic [5:0] hdr_idx;
	logic [7:0] expected;
	logic       in_header;
	logic       first;
	logic       differs;
	logic       mismatch;      // Sticky over the current frame
	logic       mismatch_next;

	// MAC, EtherType, IPv4 header, ICMP echo header
	assign tmpl = {
		cfg.mac_dst,
		cfg.mac_src,
		48'h08004500001C,
		cfg.frame_id,
		48'h400040010000, // DF, TTL 64, ICMP, zero checksum
		cfg.ip_src,
		cfg.ip_dst,
		cfg.echo_type,
		24'd0,            // Code and zero checksum
		cfg.log_id
	};

	assign in_header = beat.index < INDEX_W'(HEADER_BYTES);
	assign first     = beat.index == '0;
	assign hdr_idx   = in_header ? beat.index[5:0] : 6'd0;
	assign expected  = tmpl[hdr_idx];
	assign differs   = in_header && (beat.data != expected);

	// First byte drops what the previous frame left behind
	assign mismatch_next = (first ? 1'b0 : mismatch) | differs;

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			mismatch   <= 1'b0;
			match_done <= 1'b0;
			header_ok  <= 1'b0;
		end else begin
			match_done <= beat_valid && beat.last;
			if (beat_valid) begin
				mismatch <= mismatch_next;
				if (beat.last)
					header_ok <= !mismatch_next; // Includes the last byte itself
			end
		end
	end

endmodule

// File: hdl/ping_id_extractor.sv
// Takes the ping identifier from bytes 40 and 41 of each frame
// id_complete is low for frames that end before byte 41
`timescale 1ns/1ps

module ping_id_extractor import ping_rx_pkg::*; (
	input  logic        clk_rx,
	input  logic        rst_rx,
	input  rx_beat_t    beat,
	input  logic        beat_valid,
	output logic        id_done,
	output logic        id_complete,
	output logic [15:0] captured_id
);

	logic [7:0] id_hi;
	logic [7:0] id_lo;
	logic [7:0] hi_next;
	logic [7:0] lo_next;
	logic       is_hi;
	logic       is_lo;
	logic       seen_lo;
	logic       seen_next;

	assign is_hi     = beat.index == INDEX_W'(ID_HI_INDEX);
	assign is_lo     = beat.index == INDEX_W'(ID_LO_INDEX);
	assign hi_next   = is_hi ? beat.data : id_hi;
	assign lo_next   = is_lo ? beat.data : id_lo;
	assign seen_next = (beat.index == '0 ? 1'b0 : seen_lo) | is_lo;

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			seen_lo     <= 1'b0;
			id_done     <= 1'b0;
			id_complete <= 1'b0;
		end else begin
			id_done <= beat_valid && beat.last;
			if (beat_valid) begin
				seen_lo <= seen_next;
				if (beat.last)
					id_complete <= seen_next;
			end
		end
	end

	// Identifier bytes and output copy
	always_ff @(posedge clk_rx) begin
		if (beat_valid) begin
			id_hi <= hi_next;
			id_lo <= lo_next;
			if (beat.last)
				captured_id <= {hi_next, lo_next}; // Low byte may come on the last beat
		end
	end

endmodule

// File: hdl/ping_result_merger.sv
// Merges the header and id verdicts into one result per frame
// Output holds one entry; results arriving while it is blocked are dropped
// dropped_count saturates at FFFF
`timescale 1ns/1ps

module ping_result_merger import ping_rx_pkg::*; (
	input  logic         clk_rx,
	input  logic         rst_rx,
	input  logic         match_done,
	input  logic         header_ok,
	input  logic         id_complete,
	input  logic [15:0]  captured_id,
	output ping_result_t result,
	output logic         result_valid,
	input  logic         result_ready,
	output logic [15:0]  ping_id,
	output logic [15:0]  dropped_count
);

	result_status_e status;
	logic           load;  // New result enters the holding register
	logic           drop;

	// Short frames win over header errors
	always_comb begin
		if (!id_complete)
			status = STATUS_SHORT;
		else if (!header_ok)
			status = STATUS_MISMATCH;
		else
			status = STATUS_OK;
	end

	assign load = match_done && (!result_valid || result_ready);
	assign drop = match_done && result_valid && !result_ready;

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			result_valid  <= 1'b0;
			ping_id       <= '1;
			dropped_count <= '0;
		end else begin
			if (load)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0; // Held entry accepted

			// Updated on a match even if the result itself is dropped
			if (match_done && status == STATUS_OK)
				ping_id <= captured_id;

			if (drop && dropped_count != '1)
				dropped_count <= dropped_count + 1'b1;
		end
	end

	always_ff @(posedge clk_rx) begin
		if (load) begin
			result.ping_id <= captured_id;
			result.status  <= status;
		end
	end

endmodule

// File: hdl/ping_rx_top.sv
// Receive checker of the latency probe, single clk_rx domain
// cfg is assumed static while frames are received
// Result appears three register stages after the last byte
`timescale 1ns/1ps

module ping_rx_top import ping_rx_pkg::*; (
	input  logic         clk_rx,
	input  logic         rst_rx,
	input  ping_config_t cfg,
	input  logic [7:0]   s_data,
	input  logic         s_last,
	input  logic         s_valid,
	output ping_result_t result,
	output logic         result_valid,
	input  logic         result_ready,
	output logic [15:0]  ping_id,
	output logic [15:0]  dropped_count
);

	rx_beat_t    beat;
	logic        beat_valid;
	logic        match_done;
	logic        header_ok;
	logic        id_complete;
	logic [15:0] captured_id;

	rx_byte_indexer rx_byte_indexer_inst (
		.clk_rx     (clk_rx),
		.rst_rx     (rst_rx),
		.s_data     (s_data),
		.s_last     (s_last),
		.s_valid    (s_valid),
		.beat       (beat),
		.beat_valid (beat_valid)
	);

	echo_header_matcher echo_header_matcher_inst (
		.clk_rx     (clk_rx),
		.rst_rx     (rst_rx),
		.cfg        (cfg),
		.beat       (beat),
		.beat_valid (beat_valid),
		.match_done (match_done),
		.header_ok  (header_ok)
	);

	// id_done coincides with match_done, merger strobes on the latter
	ping_id_extractor ping_id_extractor_inst (
		.clk_rx      (clk_rx),
		.rst_rx      (rst_rx),
		.beat        (beat),
		.beat_valid  (beat_valid),
		.id_done     (),
		.id_complete (id_complete),
		.captured_id (captured_id)
	);

	ping_result_merger ping_result_merger_inst (
		.clk_rx        (clk_rx),
		.rst_rx        (rst_rx),
		.match_done    (match_done),
		.header_ok     (header_ok),
		.id_complete   (id_complete),
		.captured_id   (captured_id),
		.result        (result),
		.result_valid  (result_valid),
		.result_ready  (result_ready),
		.ping_id       (ping_id),
		.dropped_count (dropped_count)
	);

endmodule

// File: verification/ping_rx_tb.sv
// Directed testbench of ping_rx_top, one byte per beat on a single clk_rx
// cfg only changes between frames while the pipeline is idle
// Addresses, identifiers and padding come from an LFSR with a fixed seed
`timescale 1ns/1ps

module ping_rx_tb import ping_rx_pkg::*; ();

	localparam int TIMEOUT = 100; // Cycles allowed for any wait

	logic         clk_rx = 1'b0;
	logic         rst_rx;
	ping_config_t cfg;
	logic [7:0]   s_data;
	logic         s_last;
	logic         s_valid;
	ping_result_t result;
	logic         result_valid;
	logic         result_ready;
	logic [15:0]  ping_id;
	logic [15:0]  dropped_count;

	logic [31:0] lfsr_state = 32'h7320;
	logic [7:0]  frame_buf [0:255]; // Bytes of the frame to send
	int          frame_len;
	int          mismatches = 0;
	int          timeouts = 0;

	ping_rx_top ping_rx_top_inst (.*);

	always #2 clk_rx = ~clk_rx;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [47:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[46:0], lfsr_state[0]}; // One step per bit
		end
	endtask

	task automatic check_value(input string name, input logic [47:0] actual,
			input logic [47:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			mismatches++;
		end
	endtask

	// Appends the low count bytes of value, most significant first
	task automatic put_bytes(input logic [47:0] value, input int count);
		for (int i = count - 1; i >= 0; i--) begin
			frame_buf[frame_len] = value[i*8 +: 8];
			frame_len++;
		end
	endtask

	// Echo header from cfg, then the identifier and random padding
	task automatic build_frame(input logic [15:0] id, input int pad, input logic [7:0] icmp_type);
		logic [47:0] r;
		frame_len = 0;
		put_bytes(cfg.mac_dst, 6);
		put_bytes(cfg.mac_src, 6);
		put_bytes(48'h08004500001C, 6); // EtherType, version, length 28
		put_bytes({32'd0, cfg.frame_id}, 2);
		put_bytes(48'h400040010000, 6);
		put_bytes({16'd0, cfg.ip_src}, 4);
		put_bytes({16'd0, cfg.ip_dst}, 4);
		put_bytes({40'd0, icmp_type}, 1);
		put_bytes(48'd0, 3);
		put_bytes({32'd0, cfg.log_id}, 2);
		put_bytes({32'd0, id}, 2);     // Bytes 40 and 41
		for (int i = 0; i < pad; i++) begin
			rand_bits(8, r);
			put_bytes(r, 1);
		end
	endtask

	task automatic send_frame();
		for (int i = 0; i < frame_len; i++) begin
			@(posedge clk_rx);
			#1;
			s_valid = 1'b1;
			s_data  = frame_buf[i];
			s_last  = (i == frame_len - 1);
		end
		@(posedge clk_rx); // Samples the last byte
		#1;
		s_valid = 1'b0;
		s_last  = 1'b0;
	endtask

	// Counts edges after the one that sampled s_last
	task automatic wait_result(output int edges);
		for (edges = 0; !result_valid && edges < TIMEOUT; edges++) begin
			@(posedge clk_rx);
			#1;
		end
		if (!result_valid) begin
			$display("Timeout: no result came out after %0d cycles", TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; result_valid && n < TIMEOUT; n++) begin
			@(posedge clk_rx);
			#1;
		end
		if (result_valid) begin
			$display("Timeout: result_valid stayed high with result_ready high");
			timeouts++;
		end
	endtask

	task automatic run_frame(input result_status_e status, input logic [15:0] id);
		int edges;
		send_frame();
		wait_result(edges);
		check_value("latency", edges, 2); // Third edge counting the sampling edge
		check_value("result.status", result.status, status);
		if (status == STATUS_OK)
			check_value("result.ping_id", result.ping_id, id);
	endtask

	task automatic test_reset();
		check_value("ping_id", ping_id, 16'hFFFF);
		check_value("result_valid", result_valid, 0);
		check_value("dropped_count", dropped_count, 0);
	endtask

	task automatic test_match();
		logic [47:0] id;
		logic [47:0] pad;
		rand_bits(16, id);
		rand_bits(3, pad);
		build_frame(id[15:0], pad, ECHO_REQUEST);
		run_frame(STATUS_OK, id[15:0]);
		check_value("ping_id", ping_id, id[15:0]);
	endtask

	task automatic test_header_flip();
		logic [47:0] id;
		logic [47:0] pos;
		logic [47:0] flip;
		logic [15:0] prev;
		prev = ping_id;
		rand_bits(16, id);
		rand_bits(8, pos);
		rand_bits(8, flip);
		build_frame(id[15:0], 4, ECHO_REQUEST);
		frame_buf[pos % 40] ^= flip[7:0] | 8'h01; // Never a zero pattern
		run_frame(STATUS_MISMATCH, id[15:0]);
		check_value("ping_id", ping_id, prev);
	endtask

	task automatic test_short();
		logic [15:0] prev;
		prev = ping_id;
		build_frame(16'h1234, 0, ECHO_REQUEST);
		frame_len = 41; // Low id byte missing
		run_frame(STATUS_SHORT, 16'h0);
		build_frame(16'h5678, 0, ECHO_REQUEST);
		frame_buf[3] ^= 8'h80;
		frame_len = 20;
		run_frame(STATUS_SHORT, 16'h0);
		check_value("ping_id", ping_id, prev);
	endtask

	task automatic test_echo_reply();
		logic [47:0] id;
		cfg.echo_type = ECHO_REPLY;
		rand_bits(16, id);
		build_frame(id[15:0], 1, 8'h08);
		run_frame(STATUS_MISMATCH, id[15:0]);
		build_frame(id[15:0] ^ 16'h00FF, 1, 8'h00);
		run_frame(STATUS_OK, id[15:0] ^ 16'h00FF);
		check_value("ping_id", ping_id, id[15:0] ^ 16'h00FF);
		cfg.echo_type = ECHO_REQUEST;
	endtask

	task automatic test_backpressure();
		logic [47:0] id_a;
		logic [47:0] id_b;
		int          n;
		wait_idle();
		result_ready = 1'b0;
		rand_bits(16, id_a);
		rand_bits(16, id_b);
		build_frame(id_a[15:0], 2, ECHO_REQUEST);
		run_frame(STATUS_OK, id_a[15:0]);
		build_frame(id_b[15:0], 2, ECHO_REQUEST);
		send_frame();
		for (n = 0; dropped_count == 0 && n < TIMEOUT; n++) begin
			@(posedge clk_rx);
			#1;
		end
		if (dropped_count == 0) begin
			$display("Timeout: second result was never dropped");
			timeouts++;
		end
		check_value("result.status", result.status, STATUS_OK);
		check_value("result.ping_id", result.ping_id, id_a[15:0]); // First frame still held
		check_value("result_valid", result_valid, 1);
		check_value("dropped_count", dropped_count, 1);
		check_value("ping_id", ping_id, id_b[15:0]);
		result_ready = 1'b1;
		@(posedge clk_rx); // Transfer edge
		#1;
		check_value("result_valid", result_valid, 0);
	endtask

	initial begin : stimulus
		logic [47:0] r;
		rst_rx       = 1'b1;
		s_data       = '0;
		s_last       = 1'b0;
		s_valid      = 1'b0;
		result_ready = 1'b1;
		frame_len    = 0;
		rand_bits(48, r);
		cfg.mac_dst = r;
		rand_bits(48, r);
		cfg.mac_src = r;
		rand_bits(32, r);
		cfg.ip_src = r[31:0];
		rand_bits(32, r);
		cfg.ip_dst = r[31:0];
		cfg.frame_id  = 16'h4A11;
		cfg.log_id    = 16'h0001;
		cfg.echo_type = ECHO_REQUEST;
		repeat (8) @(posedge clk_rx);
		#1;
		rst_rx = 1'b0;

		test_reset();
		test_match();
		test_header_flip();
		test_short();
		test_echo_reply();
		test_backpressure();

		$display("Done: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: files.f
hdl/ping_rx_pkg.sv
hdl/rx_byte_indexer.sv
hdl/echo_header_matcher.sv
hdl/ping_id_extractor.sv
hdl/ping_result_merger.sv
hdl/ping_rx_top.sv
verification/ping_rx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = ping_rx_tb
FILELIST  = files.f
SOURCES   = $(shell cat $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
